// ==== verilog/tile_ctrl_pkg.sv ====
// bus widths, register map and AXI response codes shared by all tile control files.
package tile_ctrl_pkg;

	// internal register bus.
	localparam int ADDR_W = 8;
	localparam int DATA_W = 32;

	// register map, one word per register.
	localparam logic [ADDR_W-1:0] ADDR_IDCODE       = 8'h00;
	localparam logic [ADDR_W-1:0] ADDR_CTRL         = 8'h04; // bit 0 soft reset.
	localparam logic [ADDR_W-1:0] ADDR_CORENUM      = 8'h08;

	localparam logic [ADDR_W-1:0] ADDR_IRQ_EN       = 8'h10;
	localparam logic [ADDR_W-1:0] ADDR_SGI          = 8'h14; // write only.
	localparam logic [ADDR_W-1:0] ADDR_IRQ_PEND     = 8'h18; // write one to clear.

	localparam logic [ADDR_W-1:0] ADDR_TIMER_CTRL   = 8'h20; // bit 0 run, bit 1 reload.
	localparam logic [ADDR_W-1:0] ADDR_TIMER_PERIOD = 8'h24;
	localparam logic [ADDR_W-1:0] ADDR_TIMER_VALUE  = 8'h28; // read only.

	// identity word.
	localparam logic [DATA_W-1:0] ID_CODE = 32'h5417_0c01;

	// AXI response codes.
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// ==== verilog/tile_timer.sv ====
// periodic or one-shot timer; counts from zero up to the period and flags the end.
module tile_timer
(
	input  logic                              clk_i,
	input  logic                              rst_i,
	input  logic                              clear_i,

	input  logic                              ctrl_we_i,
	input  logic                              period_we_i,
	input  logic [tile_ctrl_pkg::DATA_W-1:0]  wdata_i,

	output logic                              running_o,
	output logic                              reload_o,
	output logic [tile_ctrl_pkg::DATA_W-1:0]  period_o,
	output logic [tile_ctrl_pkg::DATA_W-1:0]  value_o,
	output logic                              expire_o
);

	logic at_end;

	assign at_end   = (value_o == period_o);
	assign expire_o = running_o & at_end;

	always_ff @(posedge clk_i)
	begin
		if (rst_i | clear_i)
		begin
			running_o <= 1'b0;
			reload_o  <= 1'b0;
			period_o  <= '0;
			value_o   <= '0;
		end
		else
		begin
			if (running_o)
			begin
				if (at_end)
				begin
					running_o <= reload_o; // one-shot stops here.
					value_o   <= '0;
				end
				else
					value_o <= value_o + 1'b1;
			end

			// a control write restarts the count.
			if (ctrl_we_i)
			begin
				value_o   <= '0;
				running_o <= wdata_i[0];
				reload_o  <= wdata_i[1];
			end

			if (period_we_i)
				period_o <= wdata_i;
		end
	end

endmodule

// ==== verilog/irq_ctrl.sv ====
// interrupt controller; latches pending bits, masks them and issues software interrupts.
module irq_ctrl
#(
	parameter int IRQ_NUM_POW = 4
)
(
	input  logic                              clk_i,
	input  logic                              rst_i,

	input  logic [(2**IRQ_NUM_POW)-1:1]       irq_ext_i,
	input  logic                              timer_expire_i,

	input  logic                              en_we_i,
	input  logic                              pend_clr_we_i,
	input  logic                              sgi_we_i,
	input  logic [tile_ctrl_pkg::DATA_W-1:0]  wdata_i,

	output logic [(2**IRQ_NUM_POW)-1:0]       irq_en_o,
	output logic [(2**IRQ_NUM_POW)-1:0]       pending_o,
	output logic                              irq_o,
	output logic                              sgi_req_o,
	output logic [IRQ_NUM_POW-1:0]            sgi_code_o
);

	localparam int IRQ_NUM = 2**IRQ_NUM_POW;

	logic [IRQ_NUM-1:0] set_vec;
	logic [IRQ_NUM-1:0] clr_vec;

	always_comb
	begin
		set_vec = {irq_ext_i, timer_expire_i}; // timer owns line 0.
		if (sgi_we_i)
			set_vec[wdata_i[IRQ_NUM_POW-1:0]] = 1'b1;
		clr_vec = pend_clr_we_i ? wdata_i[IRQ_NUM-1:0] : '0;
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			irq_en_o  <= '0;
			pending_o <= '0;
			irq_o     <= 1'b0;
			sgi_req_o <= 1'b0;
		end
		else
		begin
			if (en_we_i)
				irq_en_o <= wdata_i[IRQ_NUM-1:0];
			pending_o <= (pending_o & ~clr_vec) | set_vec; // set beats clear.
			irq_o     <= |(pending_o & irq_en_o);
			sgi_req_o <= sgi_we_i;
		end
	end

	// code sits next to the one-cycle request.
	always_ff @(posedge clk_i)
	begin
		if (sgi_we_i)
			sgi_code_o <= wdata_i[IRQ_NUM_POW-1:0];
	end

endmodule

// ==== verilog/axil_slave_port.sv ====
// AXI4-Lite slave; turns one transaction at a time into a single-cycle register bus request.
module axil_slave_port
(
	input  logic                              clk_i,
	input  logic                              rst_i,

	input  logic                              awvalid_i,
	output logic                              awready_o,
	input  logic [tile_ctrl_pkg::ADDR_W-1:0]  awaddr_i,
	input  logic                              wvalid_i,
	output logic                              wready_o,
	input  logic [tile_ctrl_pkg::DATA_W-1:0]  wdata_i,
	output logic                              bvalid_o,
	input  logic                              bready_i,
	output logic [1:0]                        bresp_o,
	input  logic                              arvalid_i,
	output logic                              arready_o,
	input  logic [tile_ctrl_pkg::ADDR_W-1:0]  araddr_i,
	output logic                              rvalid_o,
	input  logic                              rready_i,
	output logic [tile_ctrl_pkg::DATA_W-1:0]  rdata_o,
	output logic [1:0]                        rresp_o,

	output logic                              req_o,
	output logic                              we_o,
	output logic [tile_ctrl_pkg::ADDR_W-1:0]  addr_o,
	output logic [tile_ctrl_pkg::DATA_W-1:0]  wdata_o,
	input  logic [tile_ctrl_pkg::DATA_W-1:0]  rdata_i,
	input  logic                              err_i
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_REQ  = 2'd1;
	localparam logic [1:0] ST_WAIT = 2'd2;
	localparam logic [1:0] ST_RESP = 2'd3;

	logic [1:0] state;
	logic port_en; // keeps readies low right after reset.
	logic aw_held, w_held, ar_held;
	logic op_we;
	logic resp_err;
	logic [tile_ctrl_pkg::ADDR_W-1:0] awaddr_q, araddr_q;
	logic [tile_ctrl_pkg::DATA_W-1:0] wdata_q, rdata_q;
	logic aw_hs, w_hs, ar_hs;
	logic aw_ok, w_ok, ar_ok;

	assign awready_o = port_en & (state == ST_IDLE) & ~aw_held;
	assign wready_o  = port_en & (state == ST_IDLE) & ~w_held;
	assign arready_o = port_en & (state == ST_IDLE) & ~ar_held;

	assign aw_hs = awvalid_i & awready_o;
	assign w_hs  = wvalid_i & wready_o;
	assign ar_hs = arvalid_i & arready_o;
	assign aw_ok = aw_held | aw_hs;
	assign w_ok  = w_held | w_hs;
	assign ar_ok = ar_held | ar_hs;

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			state    <= ST_IDLE;
			port_en  <= 1'b0;
			aw_held  <= 1'b0;
			w_held   <= 1'b0;
			ar_held  <= 1'b0;
			op_we    <= 1'b0;
			resp_err <= 1'b0;
		end
		else
		begin
			port_en <= 1'b1;
			case (state)
				ST_IDLE:
				begin
					if (aw_ok & w_ok) // write wins a tie.
					begin
						state   <= ST_REQ;
						op_we   <= 1'b1;
						aw_held <= 1'b0;
						w_held  <= 1'b0;
						ar_held <= ar_ok;
					end
					else if (ar_ok)
					begin
						state   <= ST_REQ;
						op_we   <= 1'b0;
						ar_held <= 1'b0;
						aw_held <= aw_ok;
						w_held  <= w_ok;
					end
					else
					begin
						aw_held <= aw_ok;
						w_held  <= w_ok;
					end
				end
				ST_REQ:  state <= ST_WAIT;
				ST_WAIT:
				begin
					resp_err <= err_i;
					state    <= ST_RESP;
				end
				default:
				begin
					if (op_we ? bready_i : rready_i)
						state <= ST_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (aw_hs)
			awaddr_q <= awaddr_i;
		if (w_hs)
			wdata_q <= wdata_i;
		if (ar_hs)
			araddr_q <= araddr_i;
		if (state == ST_WAIT)
			rdata_q <= rdata_i;
	end

	assign req_o   = (state == ST_REQ);
	assign we_o    = op_we;
	assign addr_o  = op_we ? awaddr_q : araddr_q;
	assign wdata_o = wdata_q;

	assign bvalid_o = (state == ST_RESP) & op_we;
	assign rvalid_o = (state == ST_RESP) & ~op_we;
	assign bresp_o  = resp_err ? tile_ctrl_pkg::RESP_SLVERR : tile_ctrl_pkg::RESP_OKAY;
	assign rresp_o  = resp_err ? tile_ctrl_pkg::RESP_SLVERR : tile_ctrl_pkg::RESP_OKAY;
	assign rdata_o  = rdata_q;

endmodule

// ==== verilog/sfr_regs.sv ====
// register block of one core; decodes the internal bus and holds the timer and irq controller.
module sfr_regs
#(
	parameter int CORE_NUM         = 0,
	parameter bit SW_RESET_DEFAULT = 1'b0,
	parameter int IRQ_NUM_POW      = 4
)
(
	input  logic                              clk_i,
	input  logic                              rst_i,

	input  logic                              req_i,
	input  logic                              we_i,
	input  logic [tile_ctrl_pkg::ADDR_W-1:0]  addr_i,
	input  logic [tile_ctrl_pkg::DATA_W-1:0]  wdata_i,
	output logic [tile_ctrl_pkg::DATA_W-1:0]  rdata_o,
	output logic                              err_o,

	input  logic [(2**IRQ_NUM_POW)-1:1]       irq_ext_i,
	output logic                              irq_o,
	output logic                              sw_reset_o,
	output logic                              sgi_req_o,
	output logic [IRQ_NUM_POW-1:0]            sgi_code_o
);

	localparam int IRQ_NUM = 2**IRQ_NUM_POW;

	logic wr;
	logic ctrl_we, irq_en_we, sgi_we, pend_clr_we, timer_ctrl_we, timer_period_we;
	logic sw_reset_q;
	logic mapped;
	logic [tile_ctrl_pkg::DATA_W-1:0] rd_val;

	logic timer_running, timer_reload, timer_expire;
	logic [tile_ctrl_pkg::DATA_W-1:0] timer_period, timer_value;
	logic [IRQ_NUM-1:0] irq_en, pending;

	assign wr              = req_i & we_i;
	assign ctrl_we         = wr & (addr_i == tile_ctrl_pkg::ADDR_CTRL);
	assign irq_en_we       = wr & (addr_i == tile_ctrl_pkg::ADDR_IRQ_EN);
	assign sgi_we          = wr & (addr_i == tile_ctrl_pkg::ADDR_SGI);
	assign pend_clr_we     = wr & (addr_i == tile_ctrl_pkg::ADDR_IRQ_PEND);
	assign timer_ctrl_we   = wr & (addr_i == tile_ctrl_pkg::ADDR_TIMER_CTRL);
	assign timer_period_we = wr & (addr_i == tile_ctrl_pkg::ADDR_TIMER_PERIOD);

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			sw_reset_q <= SW_RESET_DEFAULT;
		else if (ctrl_we)
			sw_reset_q <= wdata_i[0];
	end

	always_ff @(posedge clk_i)
		sw_reset_o <= rst_i | sw_reset_q; // held through reset.

	always_comb
	begin
		rd_val = '0;
		mapped = 1'b1;
		case (addr_i)
			tile_ctrl_pkg::ADDR_IDCODE:       rd_val = tile_ctrl_pkg::ID_CODE;
			tile_ctrl_pkg::ADDR_CTRL:         rd_val[0] = sw_reset_q;
			tile_ctrl_pkg::ADDR_CORENUM:      rd_val = CORE_NUM[tile_ctrl_pkg::DATA_W-1:0];
			tile_ctrl_pkg::ADDR_IRQ_EN:       rd_val[IRQ_NUM-1:0] = irq_en;
			tile_ctrl_pkg::ADDR_SGI:          rd_val = '0; // write only so it reads zero.
			tile_ctrl_pkg::ADDR_IRQ_PEND:     rd_val[IRQ_NUM-1:0] = pending;
			tile_ctrl_pkg::ADDR_TIMER_CTRL:   rd_val[1:0] = {timer_reload, timer_running};
			tile_ctrl_pkg::ADDR_TIMER_PERIOD: rd_val = timer_period;
			tile_ctrl_pkg::ADDR_TIMER_VALUE:  rd_val = timer_value;
			default:                          mapped = 1'b0;
		endcase
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			err_o <= 1'b0;
		else
			err_o <= req_i & ~mapped;
	end

	always_ff @(posedge clk_i)
	begin
		if (req_i)
			rdata_o <= rd_val;
	end

	tile_timer i_tile_timer
	(
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.clear_i     (sw_reset_o),
		.ctrl_we_i   (timer_ctrl_we),
		.period_we_i (timer_period_we),
		.wdata_i     (wdata_i),
		.running_o   (timer_running),
		.reload_o    (timer_reload),
		.period_o    (timer_period),
		.value_o     (timer_value),
		.expire_o    (timer_expire)
	);

	irq_ctrl #(
		.IRQ_NUM_POW (IRQ_NUM_POW)
	) i_irq_ctrl (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.irq_ext_i      (irq_ext_i),
		.timer_expire_i (timer_expire),
		.en_we_i        (irq_en_we),
		.pend_clr_we_i  (pend_clr_we),
		.sgi_we_i       (sgi_we),
		.wdata_i        (wdata_i),
		.irq_en_o       (irq_en),
		.pending_o      (pending),
		.irq_o          (irq_o),
		.sgi_req_o      (sgi_req_o),
		.sgi_code_o     (sgi_code_o)
	);

endmodule

// ==== verilog/tile_ctrl_top.sv ====
// per-core control tile top; AXI4-Lite port in front of the special-function registers.
module tile_ctrl_top
#(
	parameter int CORE_NUM         = 0,
	parameter bit SW_RESET_DEFAULT = 1'b0,
	parameter int IRQ_NUM_POW      = 4
)
(
	input  logic                              clk_i,
	input  logic                              rst_i,

	input  logic                              awvalid_i,
	output logic                              awready_o,
	input  logic [tile_ctrl_pkg::ADDR_W-1:0]  awaddr_i,
	input  logic                              wvalid_i,
	output logic                              wready_o,
	input  logic [tile_ctrl_pkg::DATA_W-1:0]  wdata_i,
	output logic                              bvalid_o,
	input  logic                              bready_i,
	output logic [1:0]                        bresp_o,
	input  logic                              arvalid_i,
	output logic                              arready_o,
	input  logic [tile_ctrl_pkg::ADDR_W-1:0]  araddr_i,
	output logic                              rvalid_o,
	input  logic                              rready_i,
	output logic [tile_ctrl_pkg::DATA_W-1:0]  rdata_o,
	output logic [1:0]                        rresp_o,

	input  logic [(2**IRQ_NUM_POW)-1:1]       irq_ext_i,
	output logic                              irq_o,
	output logic                              sw_reset_o,
	output logic                              sgi_req_o,
	output logic [IRQ_NUM_POW-1:0]            sgi_code_o
);

	logic                             bus_req, bus_we, bus_err;
	logic [tile_ctrl_pkg::ADDR_W-1:0] bus_addr;
	logic [tile_ctrl_pkg::DATA_W-1:0] bus_wdata, bus_rdata;

	axil_slave_port i_axil_slave_port
	(
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.awvalid_i (awvalid_i),
		.awready_o (awready_o),
		.awaddr_i  (awaddr_i),
		.wvalid_i  (wvalid_i),
		.wready_o  (wready_o),
		.wdata_i   (wdata_i),
		.bvalid_o  (bvalid_o),
		.bready_i  (bready_i),
		.bresp_o   (bresp_o),
		.arvalid_i (arvalid_i),
		.arready_o (arready_o),
		.araddr_i  (araddr_i),
		.rvalid_o  (rvalid_o),
		.rready_i  (rready_i),
		.rdata_o   (rdata_o),
		.rresp_o   (rresp_o),
		.req_o     (bus_req),
		.we_o      (bus_we),
		.addr_o    (bus_addr),
		.wdata_o   (bus_wdata),
		.rdata_i   (bus_rdata),
		.err_i     (bus_err)
	);

	sfr_regs #(
		.CORE_NUM         (CORE_NUM),
		.SW_RESET_DEFAULT (SW_RESET_DEFAULT),
		.IRQ_NUM_POW      (IRQ_NUM_POW)
	) i_sfr_regs (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.req_i      (bus_req),
		.we_i       (bus_we),
		.addr_i     (bus_addr),
		.wdata_i    (bus_wdata),
		.rdata_o    (bus_rdata),
		.err_o      (bus_err),
		.irq_ext_i  (irq_ext_i),
		.irq_o      (irq_o),
		.sw_reset_o (sw_reset_o),
		.sgi_req_o  (sgi_req_o),
		.sgi_code_o (sgi_code_o)
	);

endmodule

// ==== sim/tile_ctrl_sva.sv ====
// handshake and interrupt assertions; bound to the AXI port and to the interrupt controller.
module tile_ctrl_sva
#(
	parameter int IRQ_NUM = 16
)
(
	input logic               clk_i,
	input logic               rst_i,
	input logic [4:0]         valid_i, // aw, w, ar, b, r.
	input logic [4:0]         ready_i,
	input logic               irq_i,
	input logic [IRQ_NUM-1:0] src_i, // pending or being set.
	input logic [IRQ_NUM-1:0] en_i
);

	int fail_count = 0;

	// master side valids held until accepted.
	assert property (@(posedge clk_i) disable iff (rst_i)
		(($past(valid_i[4:2] & ~ready_i[4:2]) & ~valid_i[4:2]) == 3'b000))
	else
	begin
		$error("aw, w or ar valid dropped before its ready");
		fail_count++;
	end

	assert property (@(posedge clk_i) disable iff (rst_i)
		(($past(valid_i[1:0] & ~ready_i[1:0]) & ~valid_i[1:0]) == 2'b00))
	else
	begin
		$error("bvalid or rvalid dropped before its ready");
		fail_count++;
	end

	// a line must have been pending or set, then enabled one cycle later.
	assert property (@(posedge clk_i) disable iff (rst_i)
		irq_i |-> |($past(src_i, 2) & $past(en_i)))
	else
	begin
		$error("irq_o high without an enabled pending bit");
		fail_count++;
	end

endmodule

bind axil_slave_port tile_ctrl_sva i_port_sva
(
	.clk_i   (clk_i),
	.rst_i   (rst_i),
	.valid_i ({awvalid_i, wvalid_i, arvalid_i, bvalid_o, rvalid_o}),
	.ready_i ({awready_o, wready_o, arready_o, bready_i, rready_i}),
	.irq_i   (1'b0),
	.src_i   ('0),
	.en_i    ('0)
);

bind irq_ctrl tile_ctrl_sva #(
	.IRQ_NUM (IRQ_NUM)
) i_irq_sva (
	.clk_i   (clk_i),
	.rst_i   (rst_i),
	.valid_i (5'b00000),
	.ready_i (5'b00000),
	.irq_i   (irq_o),
	.src_i   (pending_o | set_vec),
	.en_i    (irq_en_o)
);

// ==== sim/tile_ctrl_tb.sv ====
// testbench for the tile control block; runs a table of AXI4-Lite operations against the DUT.
module tile_ctrl_tb;

	localparam int IRQ_NUM_POW = 4;
	localparam int OP_WR   = 0;
	localparam int OP_RD   = 1;
	localparam int OP_POLL = 2;
	localparam int OP_PINS = 3; // compare the output pins word.
	localparam int POLL_LIMIT = 64;
	localparam logic [31:0] ALL = 32'hffff_ffff;
	localparam logic [1:0] OKAY   = tile_ctrl_pkg::RESP_OKAY;
	localparam logic [1:0] SLVERR = tile_ctrl_pkg::RESP_SLVERR;

	logic clk_i = 1'b0;
	logic rst_i = 1'b1;
	logic awvalid_i = 1'b0, wvalid_i = 1'b0, arvalid_i = 1'b0;
	logic bready_i = 1'b0, rready_i = 1'b0;
	logic [7:0] awaddr_i = 8'h00, araddr_i = 8'h00;
	logic [31:0] wdata_i = 32'h0;
	logic [(2**IRQ_NUM_POW)-1:1] irq_ext_i = '0;
	logic awready_o, wready_o, arready_o, bvalid_o, rvalid_o;
	logic [1:0] bresp_o, rresp_o;
	logic [31:0] rdata_o;
	logic irq_o, sw_reset_o, sgi_req_o;
	logic [IRQ_NUM_POW-1:0] sgi_code_o;

	logic [31:0] lfsr_state = 32'heab99f5f;
	int cycle_cnt = 0;
	int timeout_limit = 1000000;
	logic [7:0] sgi_count = 8'd0;
	logic [IRQ_NUM_POW-1:0] sgi_last = '0;

	string row_name[$];
	int row_op[$];
	logic [7:0] row_addr[$];
	logic [31:0] row_data[$], row_exp[$], row_mask[$];
	logic [1:0] row_resp[$];

	tile_ctrl_top #(
		.CORE_NUM         (3),
		.SW_RESET_DEFAULT (1'b0),
		.IRQ_NUM_POW      (IRQ_NUM_POW)
	) i_tile_ctrl_top (
		.clk_i (clk_i), .rst_i (rst_i),
		.awvalid_i (awvalid_i), .awready_o (awready_o), .awaddr_i (awaddr_i),
		.wvalid_i (wvalid_i), .wready_o (wready_o), .wdata_i (wdata_i),
		.bvalid_o (bvalid_o), .bready_i (bready_i), .bresp_o (bresp_o),
		.arvalid_i (arvalid_i), .arready_o (arready_o), .araddr_i (araddr_i),
		.rvalid_o (rvalid_o), .rready_i (rready_i), .rdata_o (rdata_o), .rresp_o (rresp_o),
		.irq_ext_i (irq_ext_i), .irq_o (irq_o), .sw_reset_o (sw_reset_o),
		.sgi_req_o (sgi_req_o), .sgi_code_o (sgi_code_o)
	);

	always #50 clk_i = ~clk_i;

	always @(posedge clk_i)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > timeout_limit)
		begin
			$display("timeout: the run did not finish within %0d cycles", timeout_limit);
			$display("TESTBENCH FAILED");
			$fatal(1, "timeout");
		end
	end

	always @(negedge clk_i)
	begin
		if (!rst_i && sgi_req_o) // one count per pulse.
		begin
			sgi_count = sgi_count + 8'd1;
			sgi_last  = sgi_code_o;
		end
	end

	// fibonacci lfsr with taps 32 22 2 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] val);
		val = 32'h0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (exp === act)
		else
		begin
			$display("FAIL %s: expected %h, actual %h", name, exp, act);
			$display("TESTBENCH FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		logic aw_hs;
		logic w_hs;
		logic [31:0] dly;
		awaddr_i  = addr;
		awvalid_i = 1'b1;
		wdata_i   = data;
		wvalid_i  = 1'b1;
		while (awvalid_i || wvalid_i)
		begin
			aw_hs = awvalid_i & awready_o;
			w_hs  = wvalid_i & wready_o;
			@(negedge clk_i);
			if (aw_hs)
				awvalid_i = 1'b0;
			if (w_hs)
				wvalid_i = 1'b0;
		end
		while (!bvalid_o)
			@(negedge clk_i);
		rand_bits(2, dly);
		repeat (dly[1:0])
			@(negedge clk_i);
		bready_i = 1'b1;
		resp     = bresp_o;
		@(negedge clk_i);
		bready_i = 1'b0;
	endtask

	task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		logic ar_hs;
		logic [31:0] dly;
		araddr_i  = addr;
		arvalid_i = 1'b1;
		while (arvalid_i)
		begin
			ar_hs = arready_o;
			@(negedge clk_i);
			if (ar_hs)
				arvalid_i = 1'b0;
		end
		while (!rvalid_o)
			@(negedge clk_i);
		rand_bits(2, dly);
		repeat (dly[1:0])
			@(negedge clk_i);
		rready_i = 1'b1;
		data     = rdata_o;
		resp     = rresp_o;
		@(negedge clk_i);
		rready_i = 1'b0;
	endtask

	task automatic poll_reg(input int idx);
		int start;
		logic done;
		logic [31:0] data;
		logic [1:0] resp;
		start = cycle_cnt;
		done  = 1'b0;
		while (!done)
		begin
			axi_read(row_addr[idx], data, resp);
			check_value({row_name[idx], " rresp"}, {30'd0, row_resp[idx]}, {30'd0, resp});
			done = ((data & row_mask[idx]) == row_exp[idx]);
			assert (done || (cycle_cnt - start) <= POLL_LIMIT)
			else
			begin
				$display("poll %s never matched within %0d cycles", row_name[idx], POLL_LIMIT);
				$display("TESTBENCH FAILED");
				$fatal(1, "poll limit reached");
			end
		end
	endtask

	task automatic add_row(input string name, input int op, input logic [7:0] addr,
		input logic [31:0] data, input logic [31:0] exp, input logic [31:0] mask,
		input logic [1:0] resp);
		row_name.push_back(name);
		row_op.push_back(op);
		row_addr.push_back(addr);
		row_data.push_back(data);
		row_exp.push_back(exp);
		row_mask.push_back(mask);
		row_resp.push_back(resp);
	endtask

	// pins word holds sgi count [15:8], last sgi code [7:4], irq_o [1] and sw_reset_o [0].
	task automatic build_table();
		logic [31:0] rnd;
		rand_bits(16, rnd); // one bit per interrupt line.
		add_row("idcode", OP_RD, tile_ctrl_pkg::ADDR_IDCODE, 32'h0,
			tile_ctrl_pkg::ID_CODE, ALL, OKAY);
		add_row("corenum", OP_RD, tile_ctrl_pkg::ADDR_CORENUM, 32'h0, 32'd3, ALL, OKAY);
		add_row("pins_after_reset", OP_PINS, 8'h00, 32'h0, 32'h0, 32'h3, OKAY);
		add_row("irq_en_wr", OP_WR, tile_ctrl_pkg::ADDR_IRQ_EN, rnd, 32'h0, ALL, OKAY);
		add_row("irq_en_rd", OP_RD, tile_ctrl_pkg::ADDR_IRQ_EN, 32'h0, rnd, ALL, OKAY);
		add_row("period_wr", OP_WR, tile_ctrl_pkg::ADDR_TIMER_PERIOD, 32'h1234, 32'h0, ALL, OKAY);
		add_row("period_rd", OP_RD, tile_ctrl_pkg::ADDR_TIMER_PERIOD, 32'h0, 32'h1234, ALL, OKAY);
		add_row("irq_en_clear", OP_WR, tile_ctrl_pkg::ADDR_IRQ_EN, 32'h0, 32'h0, ALL, OKAY);
		add_row("sgi_wr", OP_WR, tile_ctrl_pkg::ADDR_SGI, 32'd5, 32'h0, ALL, OKAY);
		add_row("sgi_pulse", OP_PINS, 8'h00, 32'h0, 32'h0000_0150, 32'h0000_ffff, OKAY);
		add_row("sgi_pend", OP_RD, tile_ctrl_pkg::ADDR_IRQ_PEND, 32'h0, 32'h20, ALL, OKAY);
		add_row("irq_en_5", OP_WR, tile_ctrl_pkg::ADDR_IRQ_EN, 32'h20, 32'h0, ALL, OKAY);
		add_row("irq_high", OP_PINS, 8'h00, 32'h0, 32'h2, 32'h2, OKAY);
		add_row("pend_clr", OP_WR, tile_ctrl_pkg::ADDR_IRQ_PEND, 32'h20, 32'h0, ALL, OKAY);
		add_row("irq_low", OP_PINS, 8'h00, 32'h0, 32'h0, 32'h2, OKAY);
		add_row("pend_empty", OP_RD, tile_ctrl_pkg::ADDR_IRQ_PEND, 32'h0, 32'h0, ALL, OKAY);
		add_row("oneshot_period", OP_WR, tile_ctrl_pkg::ADDR_TIMER_PERIOD, 32'd20,
			32'h0, ALL, OKAY);
		add_row("oneshot_start", OP_WR, tile_ctrl_pkg::ADDR_TIMER_CTRL, 32'h1, 32'h0, ALL, OKAY);
		add_row("oneshot_poll", OP_POLL, tile_ctrl_pkg::ADDR_IRQ_PEND, 32'h0,
			32'h1, 32'h1, OKAY);
		add_row("oneshot_stopped", OP_RD, tile_ctrl_pkg::ADDR_TIMER_CTRL, 32'h0,
			32'h0, 32'h3, OKAY);
		add_row("unmapped_wr", OP_WR, 8'h3c, 32'hdead_beef, 32'h0, ALL, SLVERR);
		add_row("unmapped_rd", OP_RD, 8'h3c, 32'h0, 32'h0, ALL, SLVERR);
		add_row("timer_run", OP_WR, tile_ctrl_pkg::ADDR_TIMER_CTRL, 32'h3, 32'h0, ALL, OKAY);
		add_row("timer_running", OP_RD, tile_ctrl_pkg::ADDR_TIMER_CTRL, 32'h0, 32'h3, ALL, OKAY);
		add_row("swr_on", OP_WR, tile_ctrl_pkg::ADDR_CTRL, 32'h1, 32'h0, ALL, OKAY);
		add_row("swr_high", OP_PINS, 8'h00, 32'h0, 32'h1, 32'h1, OKAY);
		add_row("timer_cleared", OP_RD, tile_ctrl_pkg::ADDR_TIMER_CTRL, 32'h0, 32'h0, ALL, OKAY);
		add_row("swr_off", OP_WR, tile_ctrl_pkg::ADDR_CTRL, 32'h0, 32'h0, ALL, OKAY);
		add_row("swr_low", OP_PINS, 8'h00, 32'h0, 32'h0, 32'h1, OKAY);
		add_row("ctrl_rd", OP_RD, tile_ctrl_pkg::ADDR_CTRL, 32'h0, 32'h0, ALL, OKAY);
	endtask

	initial
	begin
		logic [31:0] data;
		logic [31:0] pins;
		logic [1:0] resp;
		int sva_fails;
		build_table();
		timeout_limit = row_name.size() * 64;
		repeat (2)
			@(negedge clk_i);
		rst_i = 1'b0;
		for (int i = 0; i < row_name.size(); i++)
		begin
			case (row_op[i])
				OP_WR:
				begin
					axi_write(row_addr[i], row_data[i], resp);
					check_value({row_name[i], " bresp"}, {30'd0, row_resp[i]}, {30'd0, resp});
				end
				OP_RD:
				begin
					axi_read(row_addr[i], data, resp);
					check_value(row_name[i], row_exp[i], data & row_mask[i]);
					check_value({row_name[i], " rresp"}, {30'd0, row_resp[i]}, {30'd0, resp});
				end
				OP_POLL:
					poll_reg(i);
				default:
				begin
					pins = {16'h0, sgi_count, sgi_last, 2'b00, irq_o, sw_reset_o};
					check_value(row_name[i], row_exp[i], pins & row_mask[i]);
				end
			endcase
		end
		sva_fails = i_tile_ctrl_top.i_axil_slave_port.i_port_sva.fail_count
			+ i_tile_ctrl_top.i_sfr_regs.i_irq_ctrl.i_irq_sva.fail_count;
		if (sva_fails == 0)
		begin
			$display("TESTBENCH PASSED");
			$finish;
		end
		else
		begin
			$display("%0d bound assertion failures during the run", sva_fails);
			$display("TESTBENCH FAILED");
			$fatal(1, "bound assertions failed");
		end
	end

endmodule

// ==== src.f ====
verilog/tile_ctrl_pkg.sv
verilog/tile_timer.sv
verilog/irq_ctrl.sv
verilog/axil_slave_port.sv
verilog/sfr_regs.sv
verilog/tile_ctrl_top.sv
sim/tile_ctrl_sva.sv
sim/tile_ctrl_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --assert --timing
TOP      = tile_ctrl_tb
FILELIST = src.f

BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
